// File: ringMmioTop.f
+incdir+design
design/ringBusPkg.sv
design/mmioBusPkg.sv
design/ringOpDecoder.sv
design/ringSlotStage.sv
design/ringMmioBridge.sv
design/mmioRegisterBlock.sv
design/ringMmioTop.sv
dv/ringMmioTb.sv

// File: Bender.yml
package:
  name: ringMmio

sources:
  - include_dirs:
      - design
    files:
      - design/ringBusPkg.sv
      - design/mmioBusPkg.sv
      - design/ringOpDecoder.sv
      - design/ringSlotStage.sv
      - design/ringMmioBridge.sv
      - design/mmioRegisterBlock.sv
      - design/ringMmioTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/ringMmioTb.sv

// File: dv/ringMmioTb.sv
// self-checking ring stop testbench; idle slots are driven all zero, one request is modeled in flight
`timescale 1ns/1ps
`include "ringMmio_settings.svh"

module ringMmioTb;

	localparam int RequestCount = 300;
	localparam int ResponseWaitLimit = 40;
	localparam int TimeoutCycles = RequestCount * 60;
	localparam int MsgWidth = $bits(ringBusPkg::RingMsg);

	logic clock;
	logic reset;
	ringBusPkg::RingMsg ringIn;
	ringBusPkg::RingMsg ringOut;

	mmioBusPkg::MmioData regModel [`MMIO_REG_COUNT];  // expected register contents
	ringBusPkg::RingMsg expectedResp;
	logic respPending;
	int respEarliestSlot;  // first ringIn slot that may carry the response
	int slotIndex = 0;
	int cycleCount = 0;

	ringMmioTop u_ringMmioTop
	(
		.clock(clock),
		.reset(reset),
		.ringIn(ringIn),
		.ringOut(ringOut)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;  // 4 ns period

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("timeout after %0d cycles, the run did not finish", cycleCount);
			$display("=== FAIL ===");
			$fatal(1, "simulation timeout");
		end
	end

	task automatic checkEqual(input logic [MsgWidth-1:0] got, input logic [MsgWidth-1:0] expected,
		input string what);
		if (got !== expected)
		begin
			$display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, expected);
			$display("=== FAIL ===");
			$fatal(1, "ring output mismatch");
		end
	endtask

	// any code that is neither idle nor one of the four MMIO operations
	function automatic logic [7:0] randomPlainOp();
		logic [7:0] code;
		code = 8'($urandom);
		while (code == ringBusPkg::RingOpIdle || code == ringBusPkg::RingOpLoadLong
			|| code == ringBusPkg::RingOpLoadQuad || code == ringBusPkg::RingOpStoreLong
			|| code == ringBusPkg::RingOpStoreQuad)
			code = 8'($urandom);
		return code;
	endfunction

	function automatic ringBusPkg::RingMsg randomPlainMsg(input bit allowIdle);
		ringBusPkg::RingMsg msg;
		msg = '0;
		if (allowIdle && ($urandom % 4 == 0))
			return msg;  // empty slot
		msg.seq = 16'($urandom);
		msg.opm = {8'($urandom), randomPlainOp()};
		msg.addr = $urandom;
		msg.tile = {$urandom, $urandom, $urandom, $urandom};
		return msg;
	endfunction

	function automatic ringBusPkg::RingMsg randomRequest();
		ringBusPkg::RingMsg msg;
		int pick;
		pick = $urandom % 10;
		msg.seq = 16'($urandom);
		case ($urandom % 4)
			0: msg.opm = {8'($urandom), ringBusPkg::RingOpLoadQuad};
			1: msg.opm = {8'($urandom), ringBusPkg::RingOpLoadLong};
			2: msg.opm = {8'($urandom), ringBusPkg::RingOpStoreQuad};
			default: msg.opm = {8'($urandom), ringBusPkg::RingOpStoreLong};
		endcase
		if (pick == 0)
			msg.addr = {4'hF, `MMIO_RESERVED_WINDOW, 16'($urandom)};  // reserved window
		else if (pick == 1)
			msg.addr = `MMIO_BASE + 32'(8 * (`MMIO_REG_COUNT + $urandom % 256));  // past bank
		else
			msg.addr = `MMIO_BASE + 32'(8 * ($urandom % `MMIO_REG_COUNT));
		msg.tile = {$urandom, $urandom, $urandom, $urandom};
		return msg;
	endfunction

	// applies the access to the register model and returns the response data
	function automatic mmioBusPkg::MmioData modelAccess(input logic [7:0] code,
		input logic [31:0] addr, input mmioBusPkg::MmioData data);
		logic [31:0] offset;
		int index;
		mmioBusPkg::MmioData value;
		offset = addr - `MMIO_BASE;
		index = int'(offset >> 3);
		if (addr[27:16] == `MMIO_RESERVED_WINDOW)
			return '0;
		if (index >= `MMIO_REG_COUNT)
			return '1;
		if (code == ringBusPkg::RingOpStoreQuad)
			regModel[index] = data;
		else if (code == ringBusPkg::RingOpStoreLong)
			regModel[index] = {32'h0, data[31:0]};  // upper half cleared
		value = regModel[index];
		if (code == ringBusPkg::RingOpLoadLong)
			value = {{32{value[31]}}, value[31:0]};
		return value;
	endfunction

	// drives one ring slot and checks what leaves the stop one cycle later
	task automatic stepSlot(input ringBusPkg::RingMsg msg, input bit isRequest);
		ringBusPkg::RingMsg expected;
		mmioBusPkg::MmioData respData;
		bit reserved;
		expected = msg;
		reserved = (msg.addr[27:16] == `MMIO_RESERVED_WINDOW);
		if (isRequest && !respPending)
		begin
			expected = '0;  // taken off the ring
			respData = modelAccess(msg.opm[7:0], msg.addr, msg.tile[63:0]);
			expectedResp.seq = msg.seq;
			expectedResp.opm = {msg.opm[15:8], ringBusPkg::RingOpLoadOk};
			expectedResp.addr = msg.addr;
			expectedResp.tile = {64'h0, respData};
			respPending = 1'b1;
			respEarliestSlot = slotIndex + (reserved ? 1 : `MMIO_WAIT_CYCLES + 4);
		end
		else if (respPending && (msg.opm[7:0] == ringBusPkg::RingOpIdle)
			&& (slotIndex >= respEarliestSlot))
		begin
			expected = expectedResp;  // first free slot after ok
			respPending = 1'b0;
		end
		ringIn = msg;
		@(posedge clock);
		#1;
		checkEqual(ringOut, expected, $sformatf("ring output for slot %0d", slotIndex));
		slotIndex++;
	endtask

	initial
	begin
		int holdBack;
		int waitSlots;
		void'($urandom(32'h8f06_28e2));
		reset = 1'b1;
		ringIn = '0;
		respPending = 1'b0;
		for (int r = 0; r < `MMIO_REG_COUNT; r++)
			regModel[r] = '0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		checkEqual(ringOut, '0, "ring output after reset");
		for (int i = 0; i < RequestCount; i++)
		begin
			repeat ($urandom % 4) stepSlot(randomPlainMsg(1'b1), 1'b0);
			stepSlot(randomRequest(), 1'b1);
			if ($urandom % 4 == 0)
				stepSlot(randomRequest(), 1'b1);  // stop busy, goes around again
			holdBack = $urandom % 9;
			repeat (holdBack) stepSlot(randomPlainMsg(1'b0), 1'b0);  // no free slot yet
			waitSlots = 0;
			while (respPending)
			begin
				if (waitSlots == ResponseWaitLimit)
				begin
					$display("no response for request %0d within %0d slots", i, waitSlots);
					$display("=== FAIL ===");
					$fatal(1, "missing response");
				end
				stepSlot('0, 1'b0);
				waitSlots++;
			end
		end
		repeat (4) stepSlot('0, 1'b0);  // no stray second response
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: design/ringMmioTop.sv
// one ring stop with its register target; ringIn must be driven every cycle
`timescale 1ns/1ps

module ringMmioTop
(
	input logic clock,
	input logic reset,
	input ringBusPkg::RingMsg ringIn,
	output ringBusPkg::RingMsg ringOut
);

	logic isMmio;
	logic isReserved;
	mmioBusPkg::MmioOpm mmioOpm;
	ringBusPkg::SlotSelect slotSelect;
	ringBusPkg::RingMsg insertMsg;
	mmioBusPkg::MmioReq mmioReq;
	mmioBusPkg::MmioOk mmioOk;
	mmioBusPkg::MmioData mmioReadData;

	ringOpDecoder u_ringOpDecoder
	(
		.msg(ringIn),
		.isMmio(isMmio),
		.mmioOpm(mmioOpm),
		.isReserved(isReserved)
	);

	ringMmioBridge u_ringMmioBridge
	(
		.clock(clock),
		.reset(reset),
		.ringIn(ringIn),
		.isMmio(isMmio),
		.mmioOpmIn(mmioOpm),
		.isReserved(isReserved),
		.slotSelect(slotSelect),
		.insertMsg(insertMsg),
		.mmioReq(mmioReq),
		.mmioOk(mmioOk),
		.mmioReadData(mmioReadData)
	);

	ringSlotStage u_ringSlotStage
	(
		.clock(clock),
		.reset(reset),
		.ringIn(ringIn),
		.slotSelect(slotSelect),
		.insertMsg(insertMsg),
		.ringOut(ringOut)
	);

	mmioRegisterBlock u_mmioRegisterBlock
	(
		.clock(clock),
		.reset(reset),
		.mmioReq(mmioReq),
		.mmioOk(mmioOk),
		.mmioReadData(mmioReadData)
	);

endmodule

// File: design/mmioRegisterBlock.sv
// register target; low three address bits ignored, addresses past the bank read all-ones
`timescale 1ns/1ps
`include "ringMmio_settings.svh"

module mmioRegisterBlock
(
	input logic clock,
	input logic reset,
	input mmioBusPkg::MmioReq mmioReq,
	output mmioBusPkg::MmioOk mmioOk,
	output mmioBusPkg::MmioData mmioReadData
);

	localparam int IndexWidth = $clog2(`MMIO_REG_COUNT);
	localparam int WaitWidth = $clog2(`MMIO_WAIT_CYCLES + 2);

	mmioBusPkg::MmioData regBank [`MMIO_REG_COUNT];

	logic [WaitWidth-1:0] waitCount;

	mmioBusPkg::MmioAddr offset;
	logic inBank;
	logic [IndexWidth-1:0] regIndex;
	logic isWrite;
	logic isLong;
	mmioBusPkg::MmioData regValue;
	mmioBusPkg::MmioData writeValue;
	mmioBusPkg::MmioData readValue;

	assign offset = mmioReq.addr - `MMIO_BASE;  // below base wraps out of range
	assign inBank = (offset >> 3) < `MMIO_REG_COUNT;
	assign regIndex = offset[3 +: IndexWidth];  // 8-byte stride
	assign regValue = regBank[regIndex];

	always_comb
	begin
		isWrite = 1'b0;
		isLong = 1'b0;
		case (mmioReq.opm)
			mmioBusPkg::MmioOpmReadLong:
				isLong = 1'b1;
			mmioBusPkg::MmioOpmWriteQuad:
				isWrite = 1'b1;
			mmioBusPkg::MmioOpmWriteLong:
			begin
				isWrite = 1'b1;
				isLong = 1'b1;
			end
			default:
				isLong = 1'b0;
		endcase
	end

	// long writes clear the upper half
	assign writeValue = isLong ? {32'h0, mmioReq.writeData[31:0]} : mmioReq.writeData;

	always_comb
	begin
		if (!inBank)
			readValue = '1;
		else if (isWrite)
			readValue = writeValue;  // stores echo the stored value
		else if (isLong)
			readValue = {{32{regValue[31]}}, regValue[31:0]};
		else
			readValue = regValue;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mmioOk <= mmioBusPkg::MmioOkReady;
			waitCount <= '0;
			for (int i = 0; i < `MMIO_REG_COUNT; i++)
				regBank[i] <= '0;
		end
		else if (mmioReq.opm == mmioBusPkg::MmioOpmReady)
		begin
			mmioOk <= mmioBusPkg::MmioOkReady;
			waitCount <= '0;
		end
		else if (mmioOk == mmioBusPkg::MmioOkOk)
		begin
			mmioOk <= mmioBusPkg::MmioOkReady;  // ok lasts one cycle, master drops mode
		end
		else if (waitCount == WaitWidth'(`MMIO_WAIT_CYCLES))
		begin
			mmioOk <= mmioBusPkg::MmioOkOk;
			waitCount <= '0;
			if (isWrite && inBank)
				regBank[regIndex] <= writeValue;  // commits on the ok edge only
		end
		else
		begin
			mmioOk <= mmioBusPkg::MmioOkHold;
			waitCount <= waitCount + 1'b1;
		end
	end

	// valid only while ok is asserted
	always_ff @(posedge clock)
	begin
		if (waitCount == WaitWidth'(`MMIO_WAIT_CYCLES))
			mmioReadData <= readValue;
	end

endmodule

// File: design/ringMmioBridge.sv
// one request in flight; MMIO messages seen while busy keep circling the ring
`timescale 1ns/1ps

module ringMmioBridge
(
	input logic clock,
	input logic reset,
	input ringBusPkg::RingMsg ringIn,
	input logic isMmio,
	input mmioBusPkg::MmioOpm mmioOpmIn,
	input logic isReserved,
	output ringBusPkg::SlotSelect slotSelect,
	output ringBusPkg::RingMsg insertMsg,
	output mmioBusPkg::MmioReq mmioReq,
	input mmioBusPkg::MmioOk mmioOk,
	input mmioBusPkg::MmioData mmioReadData
);

	typedef enum logic [1:0]
	{
		BridgeIdle,
		BridgeAccess,
		BridgeRespond
	} BridgeState;

	BridgeState state;
	BridgeState nextState;

	// captured request
	mmioBusPkg::MmioReq pendingReq;
	ringBusPkg::RingSeq reqSeq;
	logic [7:0] reqOrigin;
	ringBusPkg::RingAddr reqAddr;

	mmioBusPkg::MmioData respData;

	logic slotIdle;
	logic takeRequest;
	logic accessDone;

	assign slotIdle = (ringIn.opm[7:0] == ringBusPkg::RingOpIdle);
	assign takeRequest = (state == BridgeIdle) && isMmio;
	assign accessDone = (state == BridgeAccess) && (mmioOk == mmioBusPkg::MmioOkOk);

	always_comb
	begin
		nextState = state;
		case (state)
			BridgeIdle:
			begin
				if (isMmio)
				begin
					if (isReserved)
						nextState = BridgeRespond;  // no bus access
					else
						nextState = BridgeAccess;
				end
			end
			BridgeAccess:
			begin
				if (accessDone)
					nextState = BridgeRespond;
			end
			BridgeRespond:
			begin
				if (slotIdle)
					nextState = BridgeIdle;
			end
			default:
				nextState = BridgeIdle;
		endcase
	end

	// ring slot control, decided in the cycle the message is on ringIn
	always_comb
	begin
		slotSelect = ringBusPkg::SlotForward;
		if (takeRequest)
			slotSelect = ringBusPkg::SlotRemove;
		else if ((state == BridgeRespond) && slotIdle)
			slotSelect = ringBusPkg::SlotInsert;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= BridgeIdle;
		else
			state <= nextState;
	end

	// bus request register, mode rises on the first Access cycle
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mmioReq.opm <= mmioBusPkg::MmioOpmReady;
		end
		else if (state == BridgeAccess)
		begin
			if (mmioOk == mmioBusPkg::MmioOkOk)
				mmioReq.opm <= mmioBusPkg::MmioOpmReady;  // drop with the ok cycle
			else if (mmioReq.opm == mmioBusPkg::MmioOpmReady)
				mmioReq <= pendingReq;
		end
	end

	always_ff @(posedge clock)
	begin
		if (takeRequest)
		begin
			pendingReq <= '{
				opm: mmioOpmIn,
				addr: ringIn.addr,
				writeData: ringIn.tile[63:0]
			};
			reqSeq <= ringIn.seq;
			reqOrigin <= ringIn.opm[15:8];
			reqAddr <= ringIn.addr;
			respData <= '0;  // stays zero for the reserved window
		end
		else if (accessDone)
		begin
			respData <= mmioReadData;
		end
	end

	// load-ok response, read data zero-extended into the tile
	assign insertMsg = '{
		seq: reqSeq,
		opm: {reqOrigin, ringBusPkg::RingOpLoadOk},
		addr: reqAddr,
		tile: ringBusPkg::RingTile'(respData)
	};

endmodule

// File: design/ringSlotStage.sv
// single pipeline register of the stop; every forwarded message takes exactly one cycle
`timescale 1ns/1ps

module ringSlotStage
(
	input logic clock,
	input logic reset,
	input ringBusPkg::RingMsg ringIn,
	input ringBusPkg::SlotSelect slotSelect,
	input ringBusPkg::RingMsg insertMsg,
	output ringBusPkg::RingMsg ringOut
);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ringOut <= '0;  // empty slot, Idle code is zero
		end
		else
		begin
			case (slotSelect)
				ringBusPkg::SlotRemove:
					ringOut <= '0;  // request taken off the ring
				ringBusPkg::SlotInsert:
					ringOut <= insertMsg;  // response into a free slot
				default:
					ringOut <= ringIn;
			endcase
		end
	end

endmodule

// File: design/ringOpDecoder.sv
// purely combinational; only the four MMIO load/store codes map to a bus mode
`timescale 1ns/1ps
`include "ringMmio_settings.svh"

module ringOpDecoder
(
	input ringBusPkg::RingMsg msg,
	output logic isMmio,
	output mmioBusPkg::MmioOpm mmioOpm,
	output logic isReserved
);

	logic [7:0] opCode;

	assign opCode = msg.opm[7:0];  // high byte is the originator tag

	always_comb
	begin
		case (opCode)
			ringBusPkg::RingOpLoadQuad:
				mmioOpm = mmioBusPkg::MmioOpmReadQuad;
			ringBusPkg::RingOpLoadLong:
				mmioOpm = mmioBusPkg::MmioOpmReadLong;  // sign-extended on return
			ringBusPkg::RingOpStoreQuad:
				mmioOpm = mmioBusPkg::MmioOpmWriteQuad;
			ringBusPkg::RingOpStoreLong:
				mmioOpm = mmioBusPkg::MmioOpmWriteLong;
			default:
				mmioOpm = mmioBusPkg::MmioOpmReady;  // memory traffic, responses, idle
		endcase
	end

	assign isMmio = (mmioOpm != mmioBusPkg::MmioOpmReady);

	// debug window, answered without touching the bus
	assign isReserved = (msg.addr[27:16] == `MMIO_RESERVED_WINDOW);

endmodule

// File: design/mmioBusPkg.sv
// MMIO bus encodings; long modes move 32 bits inside the 64-bit data path
`include "ringMmio_settings.svh"

package mmioBusPkg;

	typedef enum logic [4:0]
	{
		MmioOpmReady     = 5'h00,
		MmioOpmReadLong  = 5'h0A,
		MmioOpmReadQuad  = 5'h0B,
		MmioOpmWriteLong = 5'h12,
		MmioOpmWriteQuad = 5'h13
	} MmioOpm;

	typedef enum logic [1:0]
	{
		MmioOkReady = 2'b00,
		MmioOkOk    = 2'b01,
		MmioOkHold  = 2'b10
	} MmioOk;

	typedef logic [`MMIO_ADDR_WIDTH-1:0] MmioAddr;
	typedef logic [`MMIO_DATA_WIDTH-1:0] MmioData;

	typedef struct packed
	{
		MmioOpm opm;
		MmioAddr addr;
		MmioData writeData;
	} MmioReq;

endpackage

// File: design/ringBusPkg.sv
// ring message layout; the Idle code must stay zero so that an all-zero message is an empty slot
`include "ringMmio_settings.svh"

package ringBusPkg;

	// high byte is the source node
	typedef logic [15:0] RingSeq;

	// low byte holds the RingOp code
	typedef logic [15:0] RingOpm;

	typedef logic [`RING_ADDR_WIDTH-1:0] RingAddr;
	typedef logic [`RING_TILE_WIDTH-1:0] RingTile;

	typedef enum logic [7:0]
	{
		RingOpIdle      = 8'h00,
		RingOpLoadX     = 8'h10,
		RingOpLoadLong  = 8'h12,
		RingOpLoadQuad  = 8'h13,
		RingOpStoreX    = 8'h20,
		RingOpStoreLong = 8'h22,
		RingOpStoreQuad = 8'h23,
		RingOpPrefetch  = 8'h30,
		RingOpLoadOk    = 8'h50  // response class, bits 7:6 = 01
	} RingOp;

	typedef struct packed
	{
		RingSeq seq;
		RingOpm opm;
		RingAddr addr;
		RingTile tile;
	} RingMsg;

	// what the stop's output register loads each cycle
	typedef enum logic [1:0]
	{
		SlotForward = 2'd0,
		SlotRemove  = 2'd1,
		SlotInsert  = 2'd2
	} SlotSelect;

endpackage

// File: design/ringMmio_settings.svh
// build-time constants; ring and MMIO addresses must both stay 32 bits, register count at least 2
`ifndef RING_MMIO_SETTINGS_SVH
`define RING_MMIO_SETTINGS_SVH

// ring message fields
`define RING_ADDR_WIDTH 32
`define RING_TILE_WIDTH 128

// MMIO bus widths
`define MMIO_ADDR_WIDTH 32
`define MMIO_DATA_WIDTH 64

// address bits 27:16 of requests that are answered locally
`define MMIO_RESERVED_WINDOW 12'h001

// register target map
`define MMIO_REG_COUNT 16
`define MMIO_BASE 32'hF000_0000

// hold cycles the target inserts before ok
`define MMIO_WAIT_CYCLES 2

`endif
